//--- divider.sv
`default_nettype none
`include "muldiv_defines.svh"

module divider (
    input  logic                    clk_i,
    input  logic                    rst_i,
    muldiv_req_if.div               req,
    output logic                    valid_o,
    output logic [`MULDIV_XLEN-1:0] rslt_o
);

    muldiv_pkg::div_state_e    state;
    logic [`MULDIV_CNT_W-1:0]  cntr;
    logic                      op_signed;
    logic                      is_rem;
    logic                      dividend_neg;
    logic                      divisor_neg;
    logic                      quot_neg;
    logic                      rem_neg;
    logic [`MULDIV_XLEN-1:0]   rem_q;       // Holds the raw dividend until CHECK
    logic [`MULDIV_XLEN-1:0]   quo_q;
    logic [`MULDIV_XLEN-1:0]   divisor_q;
    logic [`MULDIV_XLEN-1:0]   dividend_mag;
    logic [`MULDIV_XLEN-1:0]   divisor_mag;
    logic [`MULDIV_XLEN:0]     diff;
    logic                      q_bit;
    logic                      div_zero;

    assign op_signed = (req.op == rv_isa_pkg::OP_DIV) || (req.op == rv_isa_pkg::OP_REM);

    assign dividend_mag = dividend_neg ? ~rem_q + 1'b1 : rem_q;
    assign divisor_mag  = divisor_neg ? ~divisor_q + 1'b1 : divisor_q;
    assign div_zero     = (divisor_q == '0);

    // Trial subtract of the shifted partial remainder
    assign diff  = {1'b0, rem_q[`MULDIV_XLEN-2:0], quo_q[`MULDIV_XLEN-1]} - {1'b0, divisor_q};
    assign q_bit = ~diff[`MULDIV_XLEN];  // No borrow, keep the difference

    // ------------------------------
    // Control
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= muldiv_pkg::DIV_IDLE;
            cntr  <= '0;
        end else begin
            case (state)
                muldiv_pkg::DIV_IDLE: begin
                    if (req.div_start) state <= muldiv_pkg::DIV_CHECK;
                end
                muldiv_pkg::DIV_CHECK: begin
                    state <= div_zero ? muldiv_pkg::DIV_RET : muldiv_pkg::DIV_EXEC;
                    cntr  <= `MULDIV_CNT_W'(`MULDIV_XLEN - 1);
                end
                muldiv_pkg::DIV_EXEC: begin
                    if (cntr == '0) state <= muldiv_pkg::DIV_RET;
                    cntr <= cntr - 1'b1;
                end
                default: state <= muldiv_pkg::DIV_IDLE;
            endcase
        end
    end

    // ------------------------------
    // Data path
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (req.div_start) begin
            is_rem       <= (req.op == rv_isa_pkg::OP_REM) || (req.op == rv_isa_pkg::OP_REMU);
            dividend_neg <= op_signed & req.src1[`MULDIV_XLEN-1];
            divisor_neg  <= op_signed & req.src2[`MULDIV_XLEN-1];
            quot_neg     <= op_signed & (req.src1[`MULDIV_XLEN-1] ^ req.src2[`MULDIV_XLEN-1]);
            rem_neg      <= op_signed & req.src1[`MULDIV_XLEN-1];  // Follows the dividend
            rem_q        <= req.src1;
            quo_q        <= '0;
            divisor_q    <= req.src2;
        end else if (state == muldiv_pkg::DIV_CHECK) begin
            if (div_zero) begin
                quo_q    <= '1;  // All ones, remainder keeps the dividend
                quot_neg <= 1'b0;
                rem_neg  <= 1'b0;
            end else begin
                rem_q     <= '0;
                quo_q     <= dividend_mag;  // Shifted out MSB first
                divisor_q <= divisor_mag;
            end
        end else if (state == muldiv_pkg::DIV_EXEC) begin
            if (q_bit) begin
                rem_q <= diff[`MULDIV_XLEN-1:0];
                quo_q <= {quo_q[`MULDIV_XLEN-2:0], 1'b1};
            end else begin
                rem_q <= {rem_q[`MULDIV_XLEN-2:0], quo_q[`MULDIV_XLEN-1]};
                quo_q <= {quo_q[`MULDIV_XLEN-2:0], 1'b0};
            end
        end
    end

    // Min / -1 falls out as min quotient, zero remainder
    assign valid_o = (state == muldiv_pkg::DIV_RET);
    assign rslt_o  = !valid_o ? '0 :
                     is_rem   ? (rem_neg ? ~rem_q + 1'b1 : rem_q) :
                                (quot_neg ? ~quo_q + 1'b1 : quo_q);

endmodule

`default_nettype wire

//--- muldiv_defines.svh
`ifndef MULDIV_DEFINES_SVH
`define MULDIV_DEFINES_SVH

// ------------------------------
// Data path
// ------------------------------

// Operand and result width
`define MULDIV_XLEN 32

// ------------------------------
// Divider iteration counter
// ------------------------------

// Counts down one step per quotient bit
`define MULDIV_CNT_W 5

// ------------------------------
// Instruction constants
// ------------------------------

// funct7 of the M extension on the OP major opcode
`define MULDIV_FUNCT7_M 7'b0000001

`endif

//--- muldiv_issue.sv
`default_nettype none
`include "muldiv_defines.svh"

module muldiv_issue (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    valid_i,
    input  logic [31:0]             ir_i,
    input  logic [`MULDIV_XLEN-1:0] src1_i,
    input  logic [`MULDIV_XLEN-1:0] src2_i,
    input  logic                    done_i,
    output logic                    ready_o,
    muldiv_req_if.issue             req
);

    rv_isa_pkg::rv_rtype_t ir;
    logic                  is_m_op;
    logic                  is_div;
    logic                  accept;
    logic                  busy;

    // ------------------------------
    // Decode
    // ------------------------------
    assign ir = ir_i;

    assign is_m_op = (ir.opcode == rv_isa_pkg::OPC_OP) &&
                     (ir.funct7 == `MULDIV_FUNCT7_M);
    assign is_div  = (ir.funct3 >= rv_isa_pkg::OP_DIV);  // DIV, DIVU, REM, REMU

    // Non-M instructions are also taken, then dropped
    assign accept  = valid_i & ready_o;

    // ------------------------------
    // Request to the units
    // ------------------------------
    assign req.mul_start = accept & is_m_op & ~is_div;
    assign req.div_start = accept & is_m_op & is_div;
    assign req.op        = ir.funct3;
    assign req.src1      = src1_i;
    assign req.src2      = src2_i;

    // ------------------------------
    // Occupancy
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy <= 1'b0;
        end else if (done_i) begin
            busy <= 1'b0;  // Result leaves this cycle
        end else if (accept && is_m_op) begin
            busy <= 1'b1;
        end
    end

    // One operation in flight at a time
    assign ready_o = ~busy;

endmodule

`default_nettype wire

//--- muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

    // ------------------------------
    // Multiplier FSM
    // ------------------------------
    typedef enum logic [1:0] {
        MUL_IDLE = 2'd0,  // Waiting for mul_start
        MUL_EXEC = 2'd1,  // Operands latched, product formed
        MUL_RET  = 2'd2   // Result on rslt_o for one cycle
    } mul_state_e;

    // ------------------------------
    // Divider FSM
    // ------------------------------
    typedef enum logic [1:0] {
        DIV_IDLE  = 2'd0,  // Waiting for div_start
        DIV_CHECK = 2'd1,  // Zero divisor test, magnitudes
        DIV_EXEC  = 2'd2,  // One quotient bit per cycle
        DIV_RET   = 2'd3   // Sign-corrected result out
    } div_state_e;

    // Both FSMs hold a single operation, no queueing

endpackage

`default_nettype wire

//--- muldiv_req_if.sv
`default_nettype none
`include "muldiv_defines.svh"

interface muldiv_req_if;

    logic                    mul_start;  // Accept cycle of a multiply
    logic                    div_start;  // Accept cycle of a divide
    rv_isa_pkg::muldiv_op_e  op;         // funct3 of the accepted op
    logic [`MULDIV_XLEN-1:0] src1;
    logic [`MULDIV_XLEN-1:0] src2;

    modport issue (
        output mul_start,
        output div_start,
        output op,
        output src1,
        output src2
    );

    modport mul (input mul_start, input op, input src1, input src2);

    modport div (input div_start, input op, input src1, input src2);

endinterface

`default_nettype wire

//--- muldiv_unit.sv
`default_nettype none
`include "muldiv_defines.svh"

module muldiv_unit (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    valid_i,
    input  logic [31:0]             ir_i,
    input  logic [`MULDIV_XLEN-1:0] src1_i,
    input  logic [`MULDIV_XLEN-1:0] src2_i,
    output logic                    ready_o,
    output logic                    rslt_valid_o,
    output logic [`MULDIV_XLEN-1:0] rslt_o
);

    logic                    mul_valid;
    logic [`MULDIV_XLEN-1:0] mul_rslt;
    logic                    div_valid;
    logic [`MULDIV_XLEN-1:0] div_rslt;

    muldiv_req_if req ();

    // ------------------------------
    // Issue stage
    // ------------------------------
    muldiv_issue u_issue (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (valid_i),
        .ir_i    (ir_i),
        .src1_i  (src1_i),
        .src2_i  (src2_i),
        .done_i  (rslt_valid_o),  // Frees the issue slot
        .ready_o (ready_o),
        .req     (req.issue)
    );

    // ------------------------------
    // Execution units
    // ------------------------------
    multiplier u_mul (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .req     (req.mul),
        .valid_o (mul_valid),
        .rslt_o  (mul_rslt)
    );

    divider u_div (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .req     (req.div),
        .valid_o (div_valid),
        .rslt_o  (div_rslt)
    );

    // Idle unit drives zero, so OR merges
    assign rslt_o       = mul_rslt | div_rslt;
    assign rslt_valid_o = mul_valid | div_valid;

endmodule

`default_nettype wire

//--- multiplier.sv
`default_nettype none
`include "muldiv_defines.svh"

module multiplier (
    input  logic                    clk_i,
    input  logic                    rst_i,
    muldiv_req_if.mul               req,
    output logic                    valid_o,
    output logic [`MULDIV_XLEN-1:0] rslt_o
);

    muldiv_pkg::mul_state_e              state;
    logic                                src1_signed;
    logic                                src2_signed;
    logic signed [`MULDIV_XLEN:0]        multiplicand;  // 33 bits, sign or zero ext
    logic signed [`MULDIV_XLEN:0]        multiplier_q;
    logic signed [2*`MULDIV_XLEN+1:0]    full_product;
    logic        [2*`MULDIV_XLEN-1:0]    product;
    logic                                is_high;

    // MULH signs both, MULHSU only rs1
    always_comb begin
        src1_signed = 1'b0;
        src2_signed = 1'b0;
        case (req.op)
            rv_isa_pkg::OP_MULH: begin
                src1_signed = 1'b1;
                src2_signed = 1'b1;
            end
            rv_isa_pkg::OP_MULHSU: src1_signed = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= muldiv_pkg::MUL_IDLE;
        end else begin
            case (state)
                muldiv_pkg::MUL_IDLE: if (req.mul_start) state <= muldiv_pkg::MUL_EXEC;
                muldiv_pkg::MUL_EXEC: state <= muldiv_pkg::MUL_RET;
                default:              state <= muldiv_pkg::MUL_IDLE;
            endcase
        end
    end

    assign full_product = multiplicand * multiplier_q;

    always_ff @(posedge clk_i) begin
        if (req.mul_start) begin
            multiplicand <= {src1_signed & req.src1[`MULDIV_XLEN-1], req.src1};
            multiplier_q <= {src2_signed & req.src2[`MULDIV_XLEN-1], req.src2};
            is_high      <= (req.op != rv_isa_pkg::OP_MUL);
        end
        if (state == muldiv_pkg::MUL_EXEC) begin
            product <= full_product[2*`MULDIV_XLEN-1:0];  // Top 2 bits are sign copies
        end
    end

    assign valid_o = (state == muldiv_pkg::MUL_RET);
    assign rslt_o  = !valid_o ? '0 :
                     is_high  ? product[2*`MULDIV_XLEN-1:`MULDIV_XLEN] :
                                product[`MULDIV_XLEN-1:0];

endmodule

`default_nettype wire

//--- run.sh
#!/bin/bash
# Build and run the muldiv testbench, exit status carries pass or fail
cd "$(dirname "$0")" &&
    verilator --binary -Wno-fatal -f src.f --top-module tb_muldiv &&
    ./obj_dir/Vtb_muldiv ||
    exit 1

//--- rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // ------------------------------
    // Major opcodes, ir[6:0]
    // ------------------------------
    typedef enum logic [6:0] {
        OPC_LOAD    = 7'b0000011,
        OPC_CUSTOM0 = 7'b0001011,
        OPC_OP_IMM  = 7'b0010011,
        OPC_AUIPC   = 7'b0010111,
        OPC_STORE   = 7'b0100011,
        OPC_OP      = 7'b0110011,  // Register-register, carries M ops
        OPC_LUI     = 7'b0110111,
        OPC_BRANCH  = 7'b1100011,
        OPC_JALR    = 7'b1100111,
        OPC_JAL     = 7'b1101111
    } rv_opcode_e;

    // M extension funct3, multiplies below OP_DIV
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } muldiv_op_e;

    // R-type instruction layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        muldiv_op_e funct3;
        logic [4:0] rd;
        rv_opcode_e opcode;
    } rv_rtype_t;

endpackage

`default_nettype wire

//--- src.f
+incdir+.
rv_isa_pkg.sv
muldiv_pkg.sv
muldiv_req_if.sv
muldiv_issue.sv
multiplier.sv
divider.sv
muldiv_unit.sv
tb_muldiv.sv

//--- tb_muldiv.sv
`default_nettype none
`include "muldiv_defines.svh"

module tb_muldiv;

    localparam int WATCHDOG_TIME = 300 * 40 * 10;  // Ops x worst cycles x period
    localparam logic [`MULDIV_XLEN-1:0] MIN_VAL = {1'b1, {(`MULDIV_XLEN-1){1'b0}}};

    logic                    clk_i;
    logic                    rst_i;
    logic                    valid_i;
    logic [31:0]             ir_i;
    logic [`MULDIV_XLEN-1:0] src1_i;
    logic [`MULDIV_XLEN-1:0] src2_i;
    logic                    ready_o;
    logic                    rslt_valid_o;
    logic [`MULDIV_XLEN-1:0] rslt_o;

    logic [`MULDIV_XLEN-1:0] exp_q[$];      // Expected results in issue order
    string                   name_q[$];
    int                      pending;       // Accepted M ops without a result yet
    int                      accepted_cnt;
    int                      result_cnt;
    int                      seed;

    muldiv_unit DUT (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .valid_i      (valid_i),
        .ir_i         (ir_i),
        .src1_i       (src1_i),
        .src2_i       (src2_i),
        .ready_o      (ready_o),
        .rslt_valid_o (rslt_valid_o),
        .rslt_o       (rslt_o)
    );

    initial clk_i = 1'b0;
    always #5 clk_i = ~clk_i;

    // ------------------------------
    // Failure reporting
    // ------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED %s: expected %08h, actual %08h",
                                name, expected, actual));
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [31:0] ref_muldiv(input rv_isa_pkg::muldiv_op_e op,
                                               input logic [31:0] a, input logic [31:0] b);
        logic [63:0] sa;
        logic [63:0] ua;
        logic [63:0] sb;
        logic [63:0] ub;
        logic [63:0] prod;
        int          sa32;
        int          sb32;
        logic [31:0] res;
        sa   = {{32{a[31]}}, a};
        ua   = {32'b0, a};
        sb   = {{32{b[31]}}, b};
        ub   = {32'b0, b};
        sa32 = a;
        sb32 = b;
        prod = '0;
        res  = '0;
        // Products taken mod 2^64 after extending each operand
        case (op)
            rv_isa_pkg::OP_MUL: begin
                prod = ua * ub;
                res  = prod[31:0];
            end
            rv_isa_pkg::OP_MULH: begin
                prod = sa * sb;
                res  = prod[63:32];
            end
            rv_isa_pkg::OP_MULHSU: begin
                prod = sa * ub;
                res  = prod[63:32];
            end
            rv_isa_pkg::OP_MULHU: begin
                prod = ua * ub;
                res  = prod[63:32];
            end
            rv_isa_pkg::OP_DIV: begin
                if (b == '0)                    res = '1;
                else if (a == MIN_VAL && b == '1) res = MIN_VAL;  // Overflow
                else                            res = sa32 / sb32;
            end
            rv_isa_pkg::OP_DIVU: begin
                if (b == '0) res = '1;
                else         res = a / b;
            end
            rv_isa_pkg::OP_REM: begin
                if (b == '0)                    res = a;
                else if (a == MIN_VAL && b == '1) res = '0;
                else                            res = sa32 % sb32;  // Sign of dividend
            end
            default: begin
                if (b == '0) res = a;
                else         res = a % b;
            end
        endcase
        return res;
    endfunction

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    function automatic logic [31:0] make_ir(input logic [6:0] funct7, input logic [2:0] funct3,
                                            input logic [6:0] opcode);
        return {funct7, 5'd2, 5'd1, funct3, 5'd3, opcode};  // rd=x3, rs1=x1, rs2=x2
    endfunction

    // Called on a rising edge and returns on the accepting edge
    task automatic send_op(input string name, input logic [31:0] ir,
                           input logic [31:0] a, input logic [31:0] b);
        rv_isa_pkg::muldiv_op_e op;
        op = rv_isa_pkg::muldiv_op_e'(ir[14:12]);
        valid_i <= 1'b1;
        ir_i    <= ir;
        src1_i  <= a;
        src2_i  <= b;
        @(posedge clk_i);
        while (!ready_o) @(posedge clk_i);
        if (ir[6:0] == rv_isa_pkg::OPC_OP && ir[31:25] == `MULDIV_FUNCT7_M) begin
            exp_q.push_back(ref_muldiv(op, a, b));
            name_q.push_back(name);
            pending++;
            accepted_cnt++;
        end
    endtask

    task automatic issue_m_op(input string tag, input rv_isa_pkg::muldiv_op_e op,
                              input logic [31:0] a, input logic [31:0] b);
        send_op($sformatf("%s %s %08h,%08h", tag, op.name(), a, b),
                make_ir(`MULDIV_FUNCT7_M, op, rv_isa_pkg::OPC_OP), a, b);
    endtask

    task automatic release_bus();
        valid_i <= 1'b0;
    endtask

    // Returns on the first edge where the DUT takes new work again
    task automatic wait_idle();
        @(posedge clk_i);
        while (!ready_o) @(posedge clk_i);
    endtask

    // ------------------------------
    // Result comparison
    // ------------------------------
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (rslt_valid_o) begin
                if (exp_q.size() == 0) begin
                    abort_run("A result appeared with no operation outstanding");
                end else begin
                    check_value(name_q.pop_front(), exp_q.pop_front(), rslt_o);
                    pending--;
                    result_cnt++;
                end
            end else begin
                check_value("rslt_o between results", '0, rslt_o);
                if (pending > 0 && ready_o) begin
                    abort_run("ready_o is high while an operation is in flight");
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        abort_run("Watchdog expired before the tests completed");
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        rv_isa_pkg::muldiv_op_e op;
        logic [31:0]            fixed_a [3];
        logic [31:0]            fixed_b [3];
        logic [31:0]            a;
        logic [31:0]            b;
        logic [31:0]            r;
        seed         = 61042;
        pending      = 0;
        accepted_cnt = 0;
        result_cnt   = 0;
        rst_i        = 1'b1;
        valid_i      = 1'b0;
        ir_i         = '0;
        src1_i       = '0;
        src2_i       = '0;
        fixed_a[0]   = 32'd7;        // Small
        fixed_b[0]   = 32'd3;
        fixed_a[1]   = -32'd100;     // Negative dividend
        fixed_b[1]   = -32'd7;
        fixed_a[2]   = 32'd1234567;  // Mixed signs
        fixed_b[2]   = -32'd89;
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        @(posedge clk_i);

        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 3; j++) begin
                op = rv_isa_pkg::muldiv_op_e'(3'(i));
                issue_m_op("fixed", op, fixed_a[j], fixed_b[j]);
                release_bus();
                wait_idle();
            end
        end

        for (int n = 0; n < 250; n++) begin
            r = $random(seed);
            a = $random(seed);
            b = $random(seed);
            if (r[7:4] == 4'd0)      b = '0;  // Some zero divisors
            else if (r[7:4] == 4'd1) b = r[8] ? 32'd1 : '1;
            op = rv_isa_pkg::muldiv_op_e'(r[2:0]);
            issue_m_op("random", op, a, b);
        end
        release_bus();
        wait_idle();

        // Divide corner cases
        for (int i = 4; i < 8; i++) begin
            op = rv_isa_pkg::muldiv_op_e'(3'(i));
            issue_m_op("div by zero", op, 32'd123, '0);
            issue_m_op("div by zero", op, -32'd5, '0);
            issue_m_op("overflow", op, MIN_VAL, '1);
        end
        release_bus();
        wait_idle();

        // valid_i stays high across all twelve
        for (int n = 0; n < 12; n++) begin
            a  = $random(seed);
            b  = $random(seed);
            op = n[0] ? rv_isa_pkg::OP_REM : rv_isa_pkg::OP_MULHSU;
            issue_m_op("backpressure", op, a, b);
        end
        release_bus();
        wait_idle();
        check_value("accepted vs results", accepted_cnt, result_cnt);

        send_op("non-M add", make_ir(7'd0, 3'd0, rv_isa_pkg::OPC_OP), 32'd5, 32'd6);
        release_bus();
        @(negedge clk_i);
        check_value("ready after non-M add", 32'd1, {31'b0, ready_o});
        @(posedge clk_i);
        send_op("non-M addi", make_ir(`MULDIV_FUNCT7_M, 3'd0, rv_isa_pkg::OPC_OP_IMM),
                32'd5, 32'd6);
        release_bus();
        @(negedge clk_i);
        check_value("ready after non-M addi", 32'd1, {31'b0, ready_o});
        @(posedge clk_i);
        issue_m_op("after non-M", rv_isa_pkg::OP_DIVU, 32'd1000, 32'd7);
        release_bus();
        wait_idle();

        // Reset in the middle of a division
        issue_m_op("abandoned", rv_isa_pkg::OP_DIV, 32'd99999, 32'd13);
        release_bus();
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b1;
        exp_q.delete();
        name_q.delete();
        pending      = 0;
        accepted_cnt = result_cnt;
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_value("ready after reset", 32'd1, {31'b0, ready_o});
        check_value("valid after reset", 32'd0, {31'b0, rslt_valid_o});
        repeat (40) @(posedge clk_i);
        issue_m_op("after reset", rv_isa_pkg::OP_MULH, -32'd3, 32'd11);
        release_bus();
        wait_idle();

        repeat (2) @(posedge clk_i);
        if (pending == 0 && exp_q.size() == 0 && accepted_cnt == result_cnt) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            abort_run("Operations were left without a result at the end of the run");
        end
    end

endmodule

`default_nettype wire
